/* logic/rv_pkg.sv */
// Shared types, opcode constants and state encodings for the four-stage RISC-V core
`default_nettype none

package rv_pkg;

	typedef logic [31:0] word_t;
	typedef logic [4:0]  reg_idx_t;
	typedef logic [31:0] instr_t;

	// major opcodes of the kept instructions
	localparam logic [6:0] op_rtype  = 7'b0110011;
	localparam logic [6:0] op_itype  = 7'b0010011;
	localparam logic [6:0] op_load   = 7'b0000011;
	localparam logic [6:0] op_store  = 7'b0100011;
	localparam logic [6:0] op_branch = 7'b1100011;
	localparam logic [6:0] op_jal    = 7'b1101111;

	typedef enum logic [2:0] {
		alu_add,
		alu_sub,
		alu_and,
		alu_or,
		alu_slt
	} alu_op_t;

	// operand source in execute
	typedef enum logic {
		fwd_none,
		fwd_mem
	} fwd_sel_t;

	typedef enum logic [1:0] {
		st_idle,
		st_req,
		st_release,
		st_done
	} dmem_state_t;

endpackage

`default_nettype wire

/* logic/pc_unit.sv */
// Fetch address register of the core, stepped, held or redirected every cycle
`timescale 1ns/10ps
`default_nettype none

module pc_unit #(
	parameter int addr_w = 16,
	parameter logic [addr_w-1:0] reset_pc = '0
) (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              hold,
	input  logic              redirect,
	input  logic [addr_w-1:0] target_pc,
	output logic [addr_w-1:0] pc
);

	// a redirect only counts once the stall ends and forwarded load data is valid
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			pc <= reset_pc;
		end else if (!hold) begin
			if (redirect) begin
				pc <= target_pc;
			end else begin
				pc <= pc + addr_w'(4);
			end
		end
	end

endmodule

`default_nettype wire

/* logic/decode_unit.sv */
// Instruction decoder: control signals, ALU operation and sign-extended immediate
`timescale 1ns/10ps
`default_nettype none

module decode_unit (
	input  rv_pkg::instr_t   instr,
	output rv_pkg::reg_idx_t rs1,
	output rv_pkg::reg_idx_t rs2,
	output rv_pkg::reg_idx_t rd,
	output rv_pkg::word_t    imm,
	output rv_pkg::alu_op_t  alu_op,
	output logic             alu_src_imm,
	output logic             reg_write,
	output logic             mem_read,
	output logic             mem_write,
	output logic             is_branch,
	output logic             branch_ne,
	output logic             is_jal
);
	import rv_pkg::*;

	logic [6:0] opcode;
	logic [2:0] funct3;
	word_t      imm_i;
	word_t      imm_s;
	word_t      imm_b;
	word_t      imm_j;

	// funct3 mapping shared by register and immediate forms
	function automatic alu_op_t arith_op(input logic [2:0] f3, input logic sub);
		case (f3)
			3'b000:  return sub ? alu_sub : alu_add;
			3'b010:  return alu_slt;
			3'b110:  return alu_or;
			3'b111:  return alu_and;
			default: return alu_add;
		endcase
	endfunction

	assign opcode = instr[6:0];
	assign funct3 = instr[14:12];
	assign rs1    = instr[19:15];
	assign rs2    = instr[24:20];
	assign rd     = instr[11:7];

	assign imm_i = {{20{instr[31]}}, instr[31:20]};
	assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
	assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
	assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

	always_comb begin
		imm         = '0;
		alu_op      = alu_add;
		alu_src_imm = 1'b0;
		reg_write   = 1'b0;
		mem_read    = 1'b0;
		mem_write   = 1'b0;
		is_branch   = 1'b0;
		branch_ne   = 1'b0;
		is_jal      = 1'b0;
		case (opcode)
			op_rtype: begin
				reg_write = 1'b1;
				alu_op    = arith_op(funct3, instr[30]);
			end
			op_itype: begin
				reg_write   = 1'b1;
				alu_src_imm = 1'b1;
				imm         = imm_i;
				alu_op      = arith_op(funct3, 1'b0);
			end
			op_load: begin
				reg_write   = 1'b1;
				mem_read    = 1'b1;
				alu_src_imm = 1'b1;
				imm         = imm_i;
			end
			op_store: begin
				mem_write   = 1'b1;
				alu_src_imm = 1'b1;
				imm         = imm_s;
			end
			op_branch: begin
				is_branch = 1'b1;
				branch_ne = funct3[0];
				imm       = imm_b;
				alu_op    = alu_sub;
			end
			op_jal: begin
				is_jal    = 1'b1;
				reg_write = 1'b1;
				imm       = imm_j;
			end
			// anything else stays a bubble
			default: ;
		endcase
	end

endmodule

`default_nettype wire

/* logic/reg_file.sv */
// Integer register file with x0 tied to zero and write-first read bypass
`timescale 1ns/10ps
`default_nettype none

module reg_file (
	input  logic             clk,
	input  logic             rst_n,
	input  rv_pkg::reg_idx_t rs1,
	input  rv_pkg::reg_idx_t rs2,
	input  rv_pkg::reg_idx_t wr_idx,
	input  logic             wr_en,
	input  rv_pkg::word_t    wr_data,
	output rv_pkg::word_t    rs1_data,
	output rv_pkg::word_t    rs2_data
);
	import rv_pkg::*;

	word_t regs [32];

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_en && wr_idx != '0) begin
			regs[wr_idx] <= wr_data;
		end
	end

	// same-cycle write is visible to decode
	assign rs1_data = (rs1 == '0) ? '0 : (wr_en && wr_idx == rs1) ? wr_data : regs[rs1];
	assign rs2_data = (rs2 == '0) ? '0 : (wr_en && wr_idx == rs2) ? wr_data : regs[rs2];

endmodule

`default_nettype wire

/* logic/execute_unit.sv */
// Execute stage logic: operand forwarding, ALU, branch decision and redirect target
`timescale 1ns/10ps
`default_nettype none

module execute_unit #(
	parameter int addr_w = 16
) (
	input  logic [addr_w-1:0] pc,
	input  rv_pkg::word_t     rs1_data,
	input  rv_pkg::word_t     rs2_data,
	input  rv_pkg::word_t     imm,
	input  rv_pkg::word_t     mem_result,
	input  rv_pkg::fwd_sel_t  fwd_a,
	input  rv_pkg::fwd_sel_t  fwd_b,
	input  rv_pkg::alu_op_t   alu_op,
	input  logic              alu_src_imm,
	input  logic              is_branch,
	input  logic              branch_ne,
	input  logic              is_jal,
	output rv_pkg::word_t     alu_result,
	output rv_pkg::word_t     store_data,
	output logic              redirect,
	output logic [addr_w-1:0] target_pc
);
	import rv_pkg::*;

	word_t src_a;
	word_t src_b_reg;
	word_t src_b;
	word_t alu_out;
	logic  equal;

	// forwarding first, then the immediate select
	assign src_a      = (fwd_a == fwd_mem) ? mem_result : rs1_data;
	assign src_b_reg  = (fwd_b == fwd_mem) ? mem_result : rs2_data;
	assign src_b      = alu_src_imm ? imm : src_b_reg;
	assign store_data = src_b_reg;

	always_comb begin
		case (alu_op)
			alu_add: alu_out = src_a + src_b;
			alu_sub: alu_out = src_a - src_b;
			alu_and: alu_out = src_a & src_b;
			alu_or:  alu_out = src_a | src_b;
			alu_slt: alu_out = word_t'($signed(src_a) < $signed(src_b));
			default: alu_out = '0;
		endcase
	end

	// jal links pc + 4
	assign alu_result = is_jal ? word_t'(pc) + 32'd4 : alu_out;

	assign equal     = (src_a == src_b_reg);
	assign redirect  = is_jal | (is_branch & (equal ^ branch_ne));
	assign target_pc = pc + imm[addr_w-1:0];

endmodule

`default_nettype wire

/* logic/hazard_unit.sv */
// Hazard control: forwarding selects into execute and flush on a taken redirect
`timescale 1ns/10ps
`default_nettype none

module hazard_unit (
	input  rv_pkg::reg_idx_t ex_rs1,
	input  rv_pkg::reg_idx_t ex_rs2,
	input  rv_pkg::reg_idx_t mem_rd,
	input  logic             mem_reg_write,
	input  logic             redirect,
	output rv_pkg::fwd_sel_t fwd_a,
	output rv_pkg::fwd_sel_t fwd_b,
	output logic             flush
);
	import rv_pkg::*;

	logic mem_live;

	// only the memory stage can be ahead of execute with a pending write
	assign mem_live = mem_reg_write && (mem_rd != '0);

	assign fwd_a = (mem_live && mem_rd == ex_rs1) ? fwd_mem : fwd_none;
	assign fwd_b = (mem_live && mem_rd == ex_rs2) ? fwd_mem : fwd_none;

	// squash fetch and decode behind a taken branch or jal
	assign flush = redirect;

endmodule

`default_nettype wire

/* logic/dmem_seq.sv */
// Data memory sequencer: runs one four-phase req/ack access per lw or sw
`timescale 1ns/10ps
`default_nettype none

module dmem_seq #(
	parameter int addr_w = 16
) (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              mem_read,
	input  logic              mem_write,
	input  logic [addr_w-1:0] addr,
	input  rv_pkg::word_t     wdata,
	input  logic              dmem_ack,
	input  rv_pkg::word_t     dmem_rdata,
	output logic              dmem_req,
	output logic              dmem_we,
	output logic [addr_w-3:0] dmem_addr,
	output rv_pkg::word_t     dmem_wdata,
	output rv_pkg::word_t     load_data,
	output logic              mem_busy
);
	import rv_pkg::*;

	dmem_state_t state;
	dmem_state_t state_next;
	logic        mem_op;

	assign mem_op = mem_read | mem_write;

	always_comb begin
		state_next = state;
		case (state)
			st_idle:    if (mem_op) state_next = st_req;
			st_req:     if (dmem_ack) state_next = st_release;
			st_release: if (!dmem_ack) state_next = st_done;
			st_done:    state_next = st_idle;
			default:    state_next = st_idle;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state    <= st_idle;
			dmem_req <= 1'b0;
		end else begin
			state    <= state_next;
			dmem_req <= (state_next == st_req);
		end
	end

	// read data is valid while ack is high
	always_ff @(posedge clk) begin
		if (state == st_req && dmem_ack) begin
			load_data <= dmem_rdata;
		end
	end

	// request fields come straight from the held EX/MEM register
	assign dmem_we    = mem_write;
	assign dmem_addr  = addr[addr_w-1:2];
	assign dmem_wdata = wdata;

	assign mem_busy = mem_op && (state != st_done);

endmodule

`default_nettype wire

/* logic/rv_core.sv */
// Top level of the four-stage core: pipeline registers, write-back and unit instances
`timescale 1ns/10ps
`default_nettype none

module rv_core #(
	parameter int addr_w = 16,
	parameter logic [addr_w-1:0] reset_pc = '0
) (
	input  logic              clk,
	input  logic              rst_n,
	output logic [addr_w-1:0] imem_addr,
	input  rv_pkg::instr_t    imem_data,
	output logic              dmem_req,
	output logic              dmem_we,
	output logic [addr_w-3:0] dmem_addr,
	output rv_pkg::word_t     dmem_wdata,
	input  rv_pkg::word_t     dmem_rdata,
	input  logic              dmem_ack
);
	import rv_pkg::*;

	logic [addr_w-1:0] pc;
	logic [addr_w-1:0] target_pc;
	logic              redirect;
	logic              flush;
	logic              mem_busy;

	// IF/ID
	instr_t            if_id_instr;
	logic [addr_w-1:0] if_id_pc;

	// decode outputs
	reg_idx_t id_rs1, id_rs2, id_rd;
	word_t    id_imm, id_rs1_data, id_rs2_data;
	alu_op_t  id_alu_op;
	logic     id_alu_src_imm, id_reg_write, id_mem_read, id_mem_write;
	logic     id_is_branch, id_branch_ne, id_is_jal;

	// ID/EX
	logic [addr_w-1:0] id_ex_pc;
	reg_idx_t          id_ex_rs1, id_ex_rs2, id_ex_rd;
	word_t             id_ex_imm, id_ex_rs1_data, id_ex_rs2_data;
	alu_op_t           id_ex_alu_op;
	logic              id_ex_alu_src_imm, id_ex_branch_ne;
	logic              id_ex_reg_write, id_ex_mem_read, id_ex_mem_write;
	logic              id_ex_is_branch, id_ex_is_jal;

	// execute outputs
	word_t    ex_alu_result, ex_store_data;
	fwd_sel_t fwd_a, fwd_b;

	// EX/MEM, which is also write-back
	reg_idx_t ex_mem_rd;
	word_t    ex_mem_alu_result, ex_mem_store_data;
	logic     ex_mem_reg_write, ex_mem_mem_read, ex_mem_mem_write;
	word_t    load_data, wb_data;

	assign imem_addr = pc;

	// ------------------------------------------------------------------
	// pipeline registers, held as a whole while a data access runs
	// ------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			if_id_instr     <= '0;
			id_ex_reg_write <= 1'b0;
			id_ex_mem_read  <= 1'b0;
			id_ex_mem_write <= 1'b0;
			id_ex_is_branch <= 1'b0;
			id_ex_is_jal    <= 1'b0;
		end else if (!mem_busy) begin
			if_id_instr     <= flush ? '0 : imem_data;
			id_ex_reg_write <= id_reg_write & ~flush;
			id_ex_mem_read  <= id_mem_read & ~flush;
			id_ex_mem_write <= id_mem_write & ~flush;
			id_ex_is_branch <= id_is_branch & ~flush;
			id_ex_is_jal    <= id_is_jal & ~flush;
		end
	end

	always_ff @(posedge clk) begin
		if (!mem_busy) begin
			if_id_pc          <= pc;
			id_ex_pc          <= if_id_pc;
			id_ex_rs1         <= id_rs1;
			id_ex_rs2         <= id_rs2;
			id_ex_rd          <= id_rd;
			id_ex_imm         <= id_imm;
			id_ex_rs1_data    <= id_rs1_data;
			id_ex_rs2_data    <= id_rs2_data;
			id_ex_alu_op      <= id_alu_op;
			id_ex_alu_src_imm <= id_alu_src_imm;
			id_ex_branch_ne   <= id_branch_ne;
			ex_mem_rd         <= id_ex_rd;
			ex_mem_alu_result <= ex_alu_result;
			ex_mem_store_data <= ex_store_data;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			ex_mem_reg_write <= 1'b0;
			ex_mem_mem_read  <= 1'b0;
			ex_mem_mem_write <= 1'b0;
		end else if (!mem_busy) begin
			ex_mem_reg_write <= id_ex_reg_write;
			ex_mem_mem_read  <= id_ex_mem_read;
			ex_mem_mem_write <= id_ex_mem_write;
		end
	end

	// write-back, also the single forwarding source
	assign wb_data = ex_mem_mem_read ? load_data : ex_mem_alu_result;

	// ------------------------------------------------------------------
	// units
	// ------------------------------------------------------------------
	pc_unit #(.addr_w(addr_w), .reset_pc(reset_pc)) i_pc_unit (
		.clk(clk), .rst_n(rst_n), .hold(mem_busy), .redirect(redirect),
		.target_pc(target_pc), .pc(pc)
	);

	decode_unit i_decode_unit (
		.instr(if_id_instr), .rs1(id_rs1), .rs2(id_rs2), .rd(id_rd), .imm(id_imm),
		.alu_op(id_alu_op), .alu_src_imm(id_alu_src_imm), .reg_write(id_reg_write),
		.mem_read(id_mem_read), .mem_write(id_mem_write), .is_branch(id_is_branch),
		.branch_ne(id_branch_ne), .is_jal(id_is_jal)
	);

	reg_file i_reg_file (
		.clk(clk), .rst_n(rst_n), .rs1(id_rs1), .rs2(id_rs2), .wr_idx(ex_mem_rd),
		.wr_en(ex_mem_reg_write & ~mem_busy), .wr_data(wb_data),
		.rs1_data(id_rs1_data), .rs2_data(id_rs2_data)
	);

	execute_unit #(.addr_w(addr_w)) i_execute_unit (
		.pc(id_ex_pc), .rs1_data(id_ex_rs1_data), .rs2_data(id_ex_rs2_data),
		.imm(id_ex_imm), .mem_result(wb_data), .fwd_a(fwd_a), .fwd_b(fwd_b),
		.alu_op(id_ex_alu_op), .alu_src_imm(id_ex_alu_src_imm),
		.is_branch(id_ex_is_branch), .branch_ne(id_ex_branch_ne), .is_jal(id_ex_is_jal),
		.alu_result(ex_alu_result), .store_data(ex_store_data),
		.redirect(redirect), .target_pc(target_pc)
	);

	hazard_unit i_hazard_unit (
		.ex_rs1(id_ex_rs1), .ex_rs2(id_ex_rs2), .mem_rd(ex_mem_rd),
		.mem_reg_write(ex_mem_reg_write), .redirect(redirect),
		.fwd_a(fwd_a), .fwd_b(fwd_b), .flush(flush)
	);

	dmem_seq #(.addr_w(addr_w)) i_dmem_seq (
		.clk(clk), .rst_n(rst_n), .mem_read(ex_mem_mem_read), .mem_write(ex_mem_mem_write),
		.addr(ex_mem_alu_result[addr_w-1:0]), .wdata(ex_mem_store_data),
		.dmem_ack(dmem_ack), .dmem_rdata(dmem_rdata), .dmem_req(dmem_req),
		.dmem_we(dmem_we), .dmem_addr(dmem_addr), .dmem_wdata(dmem_wdata),
		.load_data(load_data), .mem_busy(mem_busy)
	);

endmodule

`default_nettype wire

/* tb/rv_core_assert.sv */
// Concurrent checks on the four-phase data handshake, bound into the core top level
`timescale 1ns/10ps
`default_nettype none

module rv_core_assert #(
	parameter int addr_w = 16
) (
	input logic                clk,
	input logic                rst_n,
	input logic                dmem_req,
	input logic                dmem_ack,
	input logic                dmem_we,
	input logic [addr_w-3:0]   dmem_addr,
	input rv_pkg::word_t       dmem_wdata,
	input rv_pkg::dmem_state_t seq_state
);
	import rv_pkg::*;

	req_held: assert property (@(posedge clk) disable iff (!rst_n)
		dmem_req && !dmem_ack |=> dmem_req)
		else $error("dmem_req dropped before dmem_ack");

	req_rise: assert property (@(posedge clk) disable iff (!rst_n)
		$rose(dmem_req) |-> !dmem_ack)
		else $error("dmem_req rose while dmem_ack was high");

	fields_stable: assert property (@(posedge clk) disable iff (!rst_n)
		dmem_req && !dmem_ack |=> $stable(dmem_addr) && $stable(dmem_we) && $stable(dmem_wdata))
		else $error("request fields changed during the access");

	// request side idle right after reset
	req_after_reset: assert property (@(posedge clk)
		!rst_n |=> !dmem_req && seq_state == st_idle)
		else $error("data sequencer not idle after reset");

endmodule

bind rv_core rv_core_assert #(.addr_w(addr_w)) i_rv_core_assert (
	.clk(clk), .rst_n(rst_n), .dmem_req(dmem_req), .dmem_ack(dmem_ack),
	.dmem_we(dmem_we), .dmem_addr(dmem_addr), .dmem_wdata(dmem_wdata),
	.seq_state(i_dmem_seq.state)
);

`default_nettype wire

/* tb/tb_rv_core.sv */
// Testbench for the four-stage core: memory models, directed programs and store-log checks
`timescale 1ns/10ps
`default_nettype none

module tb_rv_core;
	import rv_pkg::*;

	localparam int addr_w   = 16;
	localparam int n_tests  = 5;
	localparam int run_max  = 200;
	localparam int sentinel = 255;

	logic              clk;
	logic              rst_n;
	logic [addr_w-1:0] imem_addr;
	instr_t            imem_data;
	logic              dmem_req;
	logic              dmem_we;
	logic [addr_w-3:0] dmem_addr;
	word_t             dmem_wdata;
	word_t             dmem_rdata;
	logic              dmem_ack;

	instr_t            imem [256];
	word_t             dmem [1 << (addr_w - 2)];
	logic [addr_w-3:0] log_addr [$];
	word_t             log_data [$];
	logic [addr_w-3:0] exp_addr [$];
	word_t             exp_data [$];
	logic [addr_w-3:0] saved_addr [$];
	word_t             saved_data [$];
	int                prog_len;
	int                errors;
	int                seed;
	bit                zero_delay;
	bit                sentinel_seen;

	rv_core #(.addr_w(addr_w), .reset_pc('0)) i_rv_core (
		.clk(clk), .rst_n(rst_n), .imem_addr(imem_addr), .imem_data(imem_data),
		.dmem_req(dmem_req), .dmem_we(dmem_we), .dmem_addr(dmem_addr),
		.dmem_wdata(dmem_wdata), .dmem_rdata(dmem_rdata), .dmem_ack(dmem_ack)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	assign imem_data = imem[imem_addr[9:2]];

	// ------------------------------------------------------------------
	// data memory, four-phase responder with random ack delay
	// ------------------------------------------------------------------
	initial begin
		int delay;
		forever begin
			@(posedge clk);
			if (dmem_req && !dmem_ack) begin
				delay = zero_delay ? 0 : ($random(seed) & 32'h7fff_ffff) % 5;
				repeat (delay) @(posedge clk);
				if (dmem_we) begin
					dmem[dmem_addr] = dmem_wdata;
					log_addr.push_back(dmem_addr);
					log_data.push_back(dmem_wdata);
					if (dmem_addr == sentinel) begin
						sentinel_seen = 1'b1;
					end
				end else begin
					dmem_rdata <= dmem[dmem_addr];
				end
				dmem_ack <= 1'b1;
				@(posedge clk);
				while (dmem_req) @(posedge clk);
				dmem_ack <= 1'b0;
			end
		end
	end

	initial begin
		repeat (n_tests * run_max) @(posedge clk);
		$display("watchdog expired before all tests finished");
		$display("*** TEST FAILED ***");
		$finish;
	end

	// instruction encoders
	function automatic instr_t rtype_word(input logic [6:0] f7, input reg_idx_t rd,
			input reg_idx_t rs1, input reg_idx_t rs2, input logic [2:0] f3);
		return {f7, rs2, rs1, f3, rd, op_rtype};
	endfunction

	function automatic instr_t addi_word(input reg_idx_t rd, input reg_idx_t rs1,
			input logic [11:0] imm);
		return {imm, rs1, 3'b000, rd, op_itype};
	endfunction

	function automatic instr_t lw_word(input reg_idx_t rd, input logic [11:0] imm);
		return {imm, 5'd0, 3'b010, rd, op_load};
	endfunction

	function automatic instr_t sw_word(input reg_idx_t rs2, input logic [11:0] imm);
		return {imm[11:5], rs2, 5'd0, 3'b010, imm[4:0], op_store};
	endfunction

	function automatic instr_t branch_word(input logic [2:0] f3, input reg_idx_t rs1,
			input reg_idx_t rs2, input logic [12:0] off);
		return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], op_branch};
	endfunction

	function automatic instr_t jal_word(input reg_idx_t rd, input logic [20:0] off);
		return {off[20], off[10:1], off[11], off[19:12], rd, op_jal};
	endfunction

	task automatic compare_word(input string name, input word_t expected, input word_t actual);
		if (expected !== actual) begin
			errors++;
			$display("** Error at %0t: %s expected %h, got %h", $time, name, expected, actual);
		end
	endtask

	task automatic compare_addr(input string name, input logic [addr_w-3:0] expected,
			input logic [addr_w-3:0] actual);
		if (expected !== actual) begin
			errors++;
			$display("** Error at %0t: %s expected %h, got %h", $time, name, expected, actual);
		end
	endtask

	task automatic emit(input instr_t w);
		imem[prog_len] = w;
		prog_len++;
	endtask

	task automatic expect_store(input int word_addr, input word_t data);
		exp_addr.push_back(word_addr[addr_w-3:0]);
		exp_data.push_back(data);
	endtask

	// puts the core into reset, then clears program and logs
	task automatic start_program();
		@(posedge clk);
		rst_n <= 1'b0;
		for (int i = 0; i < 256; i++) begin
			imem[i] = addi_word(5'd0, 5'd0, 12'd0);
		end
		prog_len = 0;
		sentinel_seen = 1'b0;
		log_addr.delete();
		log_data.delete();
		exp_addr.delete();
		exp_data.delete();
	endtask

	task automatic end_program();
		emit(sw_word(5'd0, 12'(sentinel * 4)));
		emit(jal_word(5'd0, 21'd0));
		expect_store(sentinel, '0);
	endtask

	task automatic run_program(input string test_name);
		int n;
		n = 0;
		sentinel_seen = 1'b0;
		log_addr.delete();
		log_data.delete();
		rst_n <= 1'b0;
		repeat (5) @(posedge clk);
		rst_n <= 1'b1;
		while (!sentinel_seen && n < run_max) begin
			@(posedge clk);
			n++;
		end
		if (!sentinel_seen) begin
			errors++;
			$display("%s: program never stored to the sentinel word", test_name);
		end
		while (dmem_req || dmem_ack) @(posedge clk);
		if (log_addr.size() != exp_addr.size()) begin
			errors++;
			$display("%s: %0d stores seen where %0d were expected", test_name,
				log_addr.size(), exp_addr.size());
		end else begin
			for (int i = 0; i < exp_addr.size(); i++) begin
				compare_addr({test_name, " dmem_addr"}, exp_addr[i], log_addr[i]);
				compare_word({test_name, " dmem_wdata"}, exp_data[i], log_data[i]);
			end
		end
	endtask

	// ------------------------------------------------------------------
	// directed tests
	// ------------------------------------------------------------------
	task automatic arith_chain_test();
		word_t r1, r2, r3, r4, r5, r6, r7, r8, r9;
		start_program();
		r1 = 7;
		r2 = r1 - 3;
		r3 = r1 + r2;
		r4 = r2 - r3;
		r5 = r4 & r3;
		r6 = r5 | r2;
		r7 = word_t'($signed(r4) < $signed(r1));
		r8 = word_t'($signed(r1) < $signed(r4));
		r9 = r8 + r4;
		emit(addi_word(5'd1, 5'd0, 12'd7));
		emit(sw_word(5'd1, 12'h100));
		emit(addi_word(5'd2, 5'd1, 12'hffd));
		emit(sw_word(5'd2, 12'h104));
		emit(rtype_word(7'd0, 5'd3, 5'd1, 5'd2, 3'b000));
		emit(sw_word(5'd3, 12'h108));
		emit(rtype_word(7'h20, 5'd4, 5'd2, 5'd3, 3'b000));
		emit(sw_word(5'd4, 12'h10c));
		emit(rtype_word(7'd0, 5'd5, 5'd4, 5'd3, 3'b111));
		emit(sw_word(5'd5, 12'h110));
		emit(rtype_word(7'd0, 5'd6, 5'd5, 5'd2, 3'b110));
		emit(sw_word(5'd6, 12'h114));
		emit(rtype_word(7'd0, 5'd7, 5'd4, 5'd1, 3'b010));
		emit(sw_word(5'd7, 12'h118));
		// two dependent ALU ops back to back
		emit(rtype_word(7'd0, 5'd8, 5'd1, 5'd4, 3'b010));
		emit(rtype_word(7'd0, 5'd9, 5'd8, 5'd4, 3'b000));
		emit(sw_word(5'd9, 12'h11c));
		expect_store(64, r1);
		expect_store(65, r2);
		expect_store(66, r3);
		expect_store(67, r4);
		expect_store(68, r5);
		expect_store(69, r6);
		expect_store(70, r7);
		expect_store(71, r9);
		end_program();
		run_program("arith");
	endtask

	task automatic load_use_test();
		word_t a, b;
		start_program();
		a = dmem[80];
		b = dmem[81];
		emit(lw_word(5'd1, 12'd320));
		emit(lw_word(5'd2, 12'd324));
		emit(rtype_word(7'd0, 5'd3, 5'd1, 5'd2, 3'b000));
		emit(sw_word(5'd3, 12'h100));
		emit(lw_word(5'd4, 12'd320));
		emit(sw_word(5'd4, 12'h104));
		expect_store(64, a + b);
		expect_store(65, a);
		end_program();
		run_program("load_use");
	endtask

	task automatic branch_test();
		word_t r1, r2, r3;
		start_program();
		r1 = 3;
		r2 = 3;
		r3 = 4;
		emit(addi_word(5'd1, 5'd0, 12'd3));
		emit(addi_word(5'd2, 5'd0, 12'd3));
		emit(branch_word(3'b000, 5'd1, 5'd2, 13'd12));
		emit(sw_word(5'd1, 12'h100));
		emit(sw_word(5'd2, 12'h104));
		emit(sw_word(5'd1, 12'h108));
		emit(branch_word(3'b001, 5'd1, 5'd2, 13'd8));
		emit(sw_word(5'd2, 12'h10c));
		emit(addi_word(5'd3, 5'd0, 12'd4));
		emit(branch_word(3'b001, 5'd1, 5'd3, 13'd12));
		emit(sw_word(5'd3, 12'h110));
		emit(sw_word(5'd3, 12'h114));
		emit(branch_word(3'b000, 5'd1, 5'd3, 13'd8));
		emit(sw_word(5'd3, 12'h118));
		if (r1 != r2) begin
			expect_store(64, r1);
			expect_store(65, r2);
		end
		expect_store(66, r1);
		if (r1 == r2) expect_store(67, r2);
		if (r1 == r3) begin
			expect_store(68, r3);
			expect_store(69, r3);
		end
		if (r1 != r3) expect_store(70, r3);
		end_program();
		run_program("branch");
	endtask

	task automatic jal_test();
		start_program();
		emit(addi_word(5'd1, 5'd0, 12'd9));
		emit(jal_word(5'd5, 21'd12));
		emit(sw_word(5'd1, 12'h100));
		emit(sw_word(5'd1, 12'h104));
		emit(sw_word(5'd5, 12'h108));
		emit(jal_word(5'd6, 21'd8));
		emit(sw_word(5'd1, 12'h10c));
		emit(sw_word(5'd6, 12'h110));
		// links are the jal address plus four
		expect_store(66, 32'd4 + 32'd4);
		expect_store(68, 32'd20 + 32'd4);
		end_program();
		run_program("jal");
	endtask

	task automatic backpressure_test();
		start_program();
		emit(addi_word(5'd1, 5'd0, 12'h055));
		emit(sw_word(5'd1, 12'h100));
		emit(lw_word(5'd2, 12'h100));
		emit(addi_word(5'd3, 5'd2, 12'd1));
		emit(sw_word(5'd3, 12'h104));
		emit(lw_word(5'd4, 12'd320));
		emit(sw_word(5'd4, 12'h108));
		emit(sw_word(5'd3, 12'h10c));
		expect_store(64, 32'h55);
		expect_store(65, 32'h56);
		expect_store(66, dmem[80]);
		expect_store(67, 32'h56);
		end_program();
		zero_delay = 1'b1;
		run_program("no_delay");
		saved_addr = log_addr;
		saved_data = log_data;
		zero_delay = 1'b0;
		run_program("random_delay");
		if (saved_addr.size() != log_addr.size()) begin
			errors++;
			$display("store logs differ in length between the two delay modes");
		end else begin
			for (int i = 0; i < saved_addr.size(); i++) begin
				compare_addr("rerun dmem_addr", saved_addr[i], log_addr[i]);
				compare_word("rerun dmem_wdata", saved_data[i], log_data[i]);
			end
		end
	endtask

	initial begin
		rst_n      = 1'b0;
		dmem_ack   = 1'b0;
		dmem_rdata = '0;
		errors     = 0;
		seed       = 32'h4e1b;
		zero_delay = 1'b0;
		for (int i = 0; i < (1 << (addr_w - 2)); i++) begin
			dmem[i] = word_t'(i) * 32'h9e37_79b9 + 32'h1234_5678;
		end
		arith_chain_test();
		load_use_test();
		branch_test();
		jal_test();
		backpressure_test();
		$display("errors: %0d", errors);
		if (errors == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* verilog.f */
logic/rv_pkg.sv
logic/pc_unit.sv
logic/decode_unit.sv
logic/reg_file.sv
logic/execute_unit.sv
logic/hazard_unit.sv
logic/dmem_seq.sv
logic/rv_core.sv
tb/rv_core_assert.sv
tb/tb_rv_core.sv

/* run.sh */
#!/usr/bin/env bash
# Compile and run the core testbench with Verilator; verdict comes from sim.log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_rv_core -Mdir obj_dir -f verilog.f
if [ $? -ne 0 ]; then
	echo "compile failed"
	exit 1
fi

./obj_dir/Vtb_rv_core > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -qF "*** TEST PASSED ***" sim.log; then
	exit 0
fi
exit 1
